/* hdl/pe_msg_pkg.sv */
`default_nettype none

package pe_msg_pkg;

    localparam int COORD_WIDTH     = 4;
    localparam int COST_WIDTH      = 8;
    localparam int TIMESTAMP_WIDTH = 8;
    localparam int MAX_HOP_WIDTH   = 4;
    localparam int MSG_TYPE_WIDTH  = 4;

    typedef logic [COORD_WIDTH-1:0]     coord_t;
    typedef logic [COST_WIDTH-1:0]      cost_t;
    typedef logic [TIMESTAMP_WIDTH-1:0] tstamp_t;
    typedef logic [MAX_HOP_WIDTH-1:0]   hop_t;

    // Grid position, also the offer cache address
    typedef struct packed {
        coord_t row;
        coord_t col;
    } coord_pair_t;

    typedef enum logic [MSG_TYPE_WIDTH-1:0] {
        MSG_MATCH_OFFER       = 4'd0,
        MSG_ACCEPT_OFFER      = 4'd1,
        MSG_CONTRACT          = 4'd2,
        MSG_REFUSE_ACCEPTANCE = 4'd3
    } msg_type_e;

    typedef struct packed {
        coord_pair_t receiver;
        coord_pair_t source;
        coord_pair_t broker;
        tstamp_t     timestamp;
        cost_t       cost;
        hop_t        hops;
        msg_type_e   msg_type;
    } offer_msg_t;

    // Accept, contract and refuse all use this layout
    typedef struct packed {
        coord_pair_t receiver;
        coord_pair_t source;
        coord_pair_t sender;
        coord_pair_t target;
        logic [11:0] pad;
        msg_type_e   msg_type;
    } reply_msg_t;

    typedef union packed {
        offer_msg_t offer;
        reply_msg_t reply;
    } pe_msg_u;

    localparam coord_pair_t BROADCAST = '1;
    localparam hop_t        MAX_HOP   = 4'd15;

endpackage

`default_nettype wire

/* hdl/pe_node_pkg.sv */
`default_nettype none

package pe_node_pkg;

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_WAIT_CLEAR,
        CTRL_INITIAL_SEND,
        CTRL_PROCESSING,
        CTRL_ACCEPT_SEND
    } ctrl_state_e;

    typedef enum logic [1:0] {
        QUBIT_INITIAL,
        QUBIT_SEND_OFFER,
        QUBIT_WAITING_CONTRACT,
        QUBIT_MATCHED
    } qubit_state_e;

    // What the composer builds on an emit strobe
    typedef enum logic [2:0] {
        EMIT_OFFER,
        EMIT_FORWARD,
        EMIT_ACCEPT,
        EMIT_CONTRACT,
        EMIT_REFUSE
    } emit_kind_e;

    typedef struct packed {
        pe_msg_pkg::cost_t       cost;
        pe_msg_pkg::tstamp_t     timestamp;
        pe_msg_pkg::coord_pair_t broker;
        logic                    valid;
    } cache_entry_t;

    typedef pe_msg_pkg::coord_pair_t match_value_t;

    localparam pe_msg_pkg::cost_t NEIGHBOUR_COST = 8'd2;

    // Wraps like the hardware adder
    function automatic pe_msg_pkg::cost_t cost_add(input pe_msg_pkg::cost_t a,
                                                   input pe_msg_pkg::cost_t b);
        return a + b;
    endfunction

    // Half the Manhattan distance between two nodes
    function automatic pe_msg_pkg::cost_t cost_of_matching(input pe_msg_pkg::coord_pair_t a,
                                                           input pe_msg_pkg::coord_pair_t b);
        pe_msg_pkg::coord_t d_row;
        pe_msg_pkg::coord_t d_col;
        logic [pe_msg_pkg::COORD_WIDTH:0] d_sum;
        d_row = (a.row > b.row) ? a.row - b.row : b.row - a.row;
        d_col = (a.col > b.col) ? a.col - b.col : b.col - a.col;
        d_sum = d_row + d_col;
        return pe_msg_pkg::cost_t'(d_sum >> 1);
    endfunction

endpackage

`default_nettype wire

/* hdl/msg_intake.sv */
`timescale 1ns/1ns
`default_nettype none

module msg_intake (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire pe_msg_pkg::pe_msg_u in_msg,
    input  wire logic                in_valid,
    output logic                     in_ready,
    input  wire logic                advance,
    output pe_msg_pkg::pe_msg_u      stage_msg,
    output logic                     stage_valid,
    output pe_msg_pkg::pe_msg_u      prev_msg,
    output pe_msg_pkg::coord_pair_t  read_addr
);

    assign in_ready = advance;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else if (advance) begin
            stage_valid <= in_valid;
        end
    end

    // Stage 2 keeps the message just processed for a second reply
    always_ff @(posedge clk) begin
        if (advance) begin
            stage_msg <= in_msg;
            prev_msg  <= stage_msg;
        end
    end

    // Source sits at the same bits in both views
    always_comb begin
        if (advance) begin
            read_addr = in_msg.offer.source;
        end else begin
            read_addr = stage_msg.offer.source;
        end
    end

endmodule

`default_nettype wire

/* hdl/offer_cache.sv */
`timescale 1ns/1ns
`default_nettype none

module offer_cache (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    stop_offer,
    input  wire pe_msg_pkg::coord_pair_t read_addr,
    input  wire logic                    update,
    input  wire pe_msg_pkg::pe_msg_u     stage_msg,
    output logic                         better,
    output logic                         clearing
);

    localparam int ADDR_WIDTH = 2 * pe_msg_pkg::COORD_WIDTH;

    pe_node_pkg::cache_entry_t mem [1 << ADDR_WIDTH];
    pe_node_pkg::cache_entry_t entry;
    pe_node_pkg::cache_entry_t wr_data;
    pe_msg_pkg::coord_pair_t   wr_addr;
    logic [ADDR_WIDTH:0]       clear_cnt;
    logic                      wr_en;

    //////////////////////////////////////////////////
    // Clear sweep

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            clear_cnt <= '0;
        end else if (stop_offer) begin
            clear_cnt <= '0;
        end else if (clearing) begin
            clear_cnt <= clear_cnt + 1'b1;
        end
    end

    assign clearing = ~clear_cnt[ADDR_WIDTH];

    //////////////////////////////////////////////////
    // Write port and read with bypass

    always_comb begin
        wr_en = clearing | update;
        if (clearing) begin
            wr_addr = clear_cnt[ADDR_WIDTH-1:0];
            wr_data = '0;
        end else begin
            wr_addr           = stage_msg.offer.source;
            wr_data.cost      = stage_msg.offer.cost;
            wr_data.timestamp = stage_msg.offer.timestamp;
            wr_data.broker    = stage_msg.offer.broker;
            wr_data.valid     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // Same source back to back sees the new entry
        if (wr_en && wr_addr == read_addr) begin
            entry <= wr_data;
        end else begin
            entry <= mem[read_addr];
        end
    end

    assign better = ~entry.valid
        || ($signed(entry.cost) > $signed(stage_msg.offer.cost))
        || (entry.timestamp < stage_msg.offer.timestamp);

endmodule

`default_nettype wire

/* hdl/qubit_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module qubit_controller #(
    parameter pe_msg_pkg::coord_t ROW_ID        = 4'd0,
    parameter pe_msg_pkg::coord_t COL_ID        = 4'd0,
    parameter pe_msg_pkg::cost_t  BOUNDARY_COST = 8'd4
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                measurement_value,
    input  wire logic                measurement_valid,
    input  wire logic                start_offer,
    input  wire logic                stop_offer,
    input  wire pe_msg_pkg::pe_msg_u stage_msg,
    input  wire logic                stage_valid,
    input  wire pe_msg_pkg::pe_msg_u prev_msg,
    input  wire logic                better,
    input  wire logic                clearing,
    input  wire logic                out_free,
    output logic                     advance,
    output logic                     update,
    output logic                     emit,
    output pe_node_pkg::emit_kind_e  emit_kind,
    output pe_msg_pkg::tstamp_t      timestamp,
    output pe_msg_pkg::cost_t        qubit_cost,
    output pe_node_pkg::match_value_t match_value_out
);

    localparam pe_msg_pkg::coord_pair_t SELF_ID = '{row: ROW_ID, col: COL_ID};

    pe_node_pkg::ctrl_state_e  ctrl_state;
    pe_node_pkg::ctrl_state_e  ctrl_next;
    pe_node_pkg::qubit_state_e qubit_state;
    pe_node_pkg::qubit_state_e qubit_next;
    pe_node_pkg::match_value_t match;
    logic                      measured;
    logic                      record_match;
    logic                      accept_ok;

    assign advance = (ctrl_state == pe_node_pkg::CTRL_PROCESSING) && out_free && !stop_offer;
    assign match_value_out = measured ? match : '1;

    // Offer held in stage 2 is cheap enough to accept
    assign accept_ok = (prev_msg.offer.source != SELF_ID)
        && ($signed(prev_msg.offer.cost) < $signed(qubit_cost));

    //////////////////////////////////////////////////
    // Next state and message decisions

    always_comb begin
        ctrl_next    = ctrl_state;
        qubit_next   = qubit_state;
        emit         = 1'b0;
        emit_kind    = pe_node_pkg::EMIT_OFFER;
        update       = 1'b0;
        record_match = 1'b0;
        if (stop_offer) begin
            ctrl_next  = pe_node_pkg::CTRL_IDLE;
            qubit_next = pe_node_pkg::QUBIT_INITIAL;
        end else begin
            case (ctrl_state)
                pe_node_pkg::CTRL_IDLE: begin
                    qubit_next = pe_node_pkg::QUBIT_INITIAL;
                    if (start_offer) begin
                        ctrl_next = clearing ? pe_node_pkg::CTRL_WAIT_CLEAR
                                             : pe_node_pkg::CTRL_INITIAL_SEND;
                    end
                end
                pe_node_pkg::CTRL_WAIT_CLEAR: begin
                    if (!clearing) begin
                        ctrl_next = pe_node_pkg::CTRL_INITIAL_SEND;
                    end
                end
                pe_node_pkg::CTRL_INITIAL_SEND: begin
                    if (!measured) begin
                        ctrl_next = pe_node_pkg::CTRL_PROCESSING;
                    end else if (out_free) begin
                        emit       = 1'b1;
                        qubit_next = pe_node_pkg::QUBIT_SEND_OFFER;
                        ctrl_next  = pe_node_pkg::CTRL_PROCESSING;
                    end
                end
                pe_node_pkg::CTRL_PROCESSING: begin
                    if (advance && stage_valid) begin
                        case (stage_msg.offer.msg_type)
                            pe_msg_pkg::MSG_MATCH_OFFER: begin
                                if (better) begin
                                    update    = 1'b1;
                                    emit      = 1'b1;
                                    emit_kind = pe_node_pkg::EMIT_FORWARD;
                                    if (qubit_state == pe_node_pkg::QUBIT_SEND_OFFER) begin
                                        ctrl_next = pe_node_pkg::CTRL_ACCEPT_SEND;
                                    end
                                end
                            end
                            pe_msg_pkg::MSG_ACCEPT_OFFER: begin
                                if (stage_msg.reply.source == SELF_ID) begin
                                    emit      = 1'b1;
                                    emit_kind = pe_node_pkg::EMIT_REFUSE;
                                    if (qubit_state == pe_node_pkg::QUBIT_SEND_OFFER) begin
                                        emit_kind    = pe_node_pkg::EMIT_CONTRACT;
                                        qubit_next   = pe_node_pkg::QUBIT_MATCHED;
                                        record_match = 1'b1;
                                    end
                                end
                            end
                            pe_msg_pkg::MSG_CONTRACT: begin
                                if (stage_msg.reply.target == SELF_ID
                                        && qubit_state == pe_node_pkg::QUBIT_WAITING_CONTRACT) begin
                                    qubit_next   = pe_node_pkg::QUBIT_MATCHED;
                                    record_match = 1'b1;
                                end
                            end
                            pe_msg_pkg::MSG_REFUSE_ACCEPTANCE: begin
                                // Offer again after a refusal
                                if (stage_msg.reply.target == SELF_ID
                                        && qubit_state != pe_node_pkg::QUBIT_MATCHED) begin
                                    qubit_next = pe_node_pkg::QUBIT_SEND_OFFER;
                                    ctrl_next  = pe_node_pkg::CTRL_INITIAL_SEND;
                                end
                            end
                            default: begin
                            end
                        endcase
                    end
                end
                pe_node_pkg::CTRL_ACCEPT_SEND: begin
                    if (!accept_ok) begin
                        ctrl_next = pe_node_pkg::CTRL_PROCESSING;
                    end else if (out_free) begin
                        emit       = 1'b1;
                        emit_kind  = pe_node_pkg::EMIT_ACCEPT;
                        qubit_next = pe_node_pkg::QUBIT_WAITING_CONTRACT;
                        ctrl_next  = pe_node_pkg::CTRL_PROCESSING;
                    end
                end
                default: begin
                    ctrl_next = pe_node_pkg::CTRL_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // State registers

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl_state  <= pe_node_pkg::CTRL_IDLE;
            qubit_state <= pe_node_pkg::QUBIT_INITIAL;
            measured    <= 1'b0;
            timestamp   <= '0;
        end else begin
            ctrl_state  <= ctrl_next;
            qubit_state <= qubit_next;
            if (ctrl_state == pe_node_pkg::CTRL_IDLE && measurement_valid) begin
                measured <= measurement_value;
            end
            if (ctrl_state == pe_node_pkg::CTRL_IDLE) begin
                timestamp <= '0;
            end else begin
                timestamp <= timestamp + 1'b1;
            end
        end
    end

    // Partner is the sender of the accept or contract
    always_ff @(posedge clk) begin
        if (ctrl_state == pe_node_pkg::CTRL_IDLE) begin
            match      <= pe_msg_pkg::BROADCAST;
            qubit_cost <= BOUNDARY_COST;
        end else if (record_match) begin
            match      <= stage_msg.reply.sender;
            qubit_cost <= pe_node_pkg::cost_of_matching(SELF_ID, stage_msg.reply.sender);
        end
    end

endmodule

`default_nettype wire

/* hdl/msg_composer.sv */
`timescale 1ns/1ns
`default_nettype none

module msg_composer #(
    parameter pe_msg_pkg::coord_t ROW_ID = 4'd0,
    parameter pe_msg_pkg::coord_t COL_ID = 4'd0
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    emit,
    input  wire pe_node_pkg::emit_kind_e emit_kind,
    input  wire pe_msg_pkg::pe_msg_u     stage_msg,
    input  wire pe_msg_pkg::pe_msg_u     prev_msg,
    input  wire pe_msg_pkg::tstamp_t     timestamp,
    input  wire pe_msg_pkg::cost_t       qubit_cost,
    output pe_msg_pkg::pe_msg_u          out_msg,
    output logic                         out_valid,
    input  wire logic                    out_ready,
    output logic                         out_free
);

    localparam pe_msg_pkg::coord_pair_t SELF_ID = '{row: ROW_ID, col: COL_ID};

    pe_msg_pkg::pe_msg_u word;

    always_comb begin
        word = '0;
        case (emit_kind)
            pe_node_pkg::EMIT_OFFER: begin
                word.offer.receiver  = pe_msg_pkg::BROADCAST;
                word.offer.source    = SELF_ID;
                word.offer.broker    = SELF_ID;
                word.offer.timestamp = timestamp;
                word.offer.cost      = pe_node_pkg::cost_add(pe_node_pkg::NEIGHBOUR_COST,
                                                             -qubit_cost);
                word.offer.hops      = pe_msg_pkg::MAX_HOP;
                word.offer.msg_type  = pe_msg_pkg::MSG_MATCH_OFFER;
            end
            pe_node_pkg::EMIT_FORWARD: begin
                word.offer          = stage_msg.offer;
                word.offer.receiver = pe_msg_pkg::BROADCAST;
                word.offer.cost     = pe_node_pkg::cost_add(stage_msg.offer.cost,
                                                            pe_node_pkg::NEIGHBOUR_COST);
            end
            pe_node_pkg::EMIT_ACCEPT: begin
                word.reply.receiver = prev_msg.offer.broker;
                word.reply.source   = prev_msg.offer.source;
                word.reply.sender   = SELF_ID;
                word.reply.target   = SELF_ID;
                word.reply.msg_type = pe_msg_pkg::MSG_ACCEPT_OFFER;
            end
            default: begin
                // Answer to an accept aimed at this node
                word.reply.receiver = stage_msg.reply.sender;
                word.reply.source   = SELF_ID;
                word.reply.sender   = SELF_ID;
                word.reply.target   = stage_msg.reply.target;
                word.reply.msg_type = (emit_kind == pe_node_pkg::EMIT_CONTRACT)
                    ? pe_msg_pkg::MSG_CONTRACT : pe_msg_pkg::MSG_REFUSE_ACCEPTANCE;
            end
        endcase
    end

    // Free when empty or being taken on this edge
    assign out_free = !out_valid || out_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (emit) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            out_msg <= word;
        end
    end

endmodule

`default_nettype wire

/* hdl/pe_top.sv */
`timescale 1ns/1ns
`default_nettype none

module pe_top #(
    parameter pe_msg_pkg::coord_t ROW_ID        = 4'd0,
    parameter pe_msg_pkg::coord_t COL_ID        = 4'd0,
    parameter pe_msg_pkg::cost_t  BOUNDARY_COST = 8'd4
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 measurement_value,
    input  wire logic                 measurement_valid,
    input  wire logic                 start_offer,
    input  wire logic                 stop_offer,
    input  wire pe_msg_pkg::pe_msg_u  in_msg,
    input  wire logic                 in_valid,
    output logic                      in_ready,
    output pe_msg_pkg::pe_msg_u       out_msg,
    output logic                      out_valid,
    input  wire logic                 out_ready,
    output pe_node_pkg::match_value_t match_value_out
);

    pe_msg_pkg::pe_msg_u     stage_msg;
    pe_msg_pkg::pe_msg_u     prev_msg;
    pe_msg_pkg::coord_pair_t read_addr;
    pe_msg_pkg::tstamp_t     timestamp;
    pe_msg_pkg::cost_t       qubit_cost;
    pe_node_pkg::emit_kind_e emit_kind;
    logic                    stage_valid;
    logic                    advance;
    logic                    better;
    logic                    clearing;
    logic                    update;
    logic                    emit;
    logic                    out_free;

    msg_intake u_intake (
        .clk, .reset, .in_msg, .in_valid, .in_ready, .advance,
        .stage_msg, .stage_valid, .prev_msg, .read_addr
    );

    offer_cache u_cache (
        .clk, .reset, .stop_offer, .read_addr, .update, .stage_msg,
        .better, .clearing
    );

    qubit_controller #(
        .ROW_ID(ROW_ID),
        .COL_ID(COL_ID),
        .BOUNDARY_COST(BOUNDARY_COST)
    ) u_ctrl (
        .clk, .reset, .measurement_value, .measurement_valid, .start_offer, .stop_offer,
        .stage_msg, .stage_valid, .prev_msg, .better, .clearing, .out_free,
        .advance, .update, .emit, .emit_kind, .timestamp, .qubit_cost, .match_value_out
    );

    msg_composer #(
        .ROW_ID(ROW_ID),
        .COL_ID(COL_ID)
    ) u_composer (
        .clk, .reset, .emit, .emit_kind, .stage_msg, .prev_msg, .timestamp, .qubit_cost,
        .out_msg, .out_valid, .out_ready, .out_free
    );

endmodule

`default_nettype wire

/* testbench/tb_pe.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_pe;

    localparam pe_msg_pkg::coord_t      ROW_ID        = 4'd3;
    localparam pe_msg_pkg::coord_t      COL_ID        = 4'd5;
    localparam pe_msg_pkg::cost_t       BOUNDARY_COST = 8'd6;
    localparam pe_msg_pkg::coord_pair_t SELF_ID       = '{row: ROW_ID, col: COL_ID};
    localparam int CYCLES_PER_RECORD = 400;
    // Long enough to cover a full 256-entry clear sweep
    localparam int WAIT_LIMIT        = 400;

    logic                      clk;
    logic                      reset;
    logic                      measurement_value;
    logic                      measurement_valid;
    logic                      start_offer;
    logic                      stop_offer;
    pe_msg_pkg::pe_msg_u       in_msg;
    logic                      in_valid;
    logic                      in_ready;
    pe_msg_pkg::pe_msg_u       out_msg;
    logic                      out_valid;
    logic                      out_ready;
    pe_node_pkg::match_value_t match_value_out;

    byte         rec_kind [$];
    logic [47:0] rec_arg  [$];
    string       rec_name [$];
    logic [47:0] pending  [$];
    logic [47:0] captured [$];
    string       test_name;
    int          value_errors;
    int          other_errors;
    int          watchdog_cycles;
    logic        loaded;

    pe_top #(
        .ROW_ID(ROW_ID),
        .COL_ID(COL_ID),
        .BOUNDARY_COST(BOUNDARY_COST)
    ) uut (
        .clk, .reset, .measurement_value, .measurement_valid, .start_offer, .stop_offer,
        .in_msg, .in_valid, .in_ready, .out_msg, .out_valid, .out_ready, .match_value_out
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // Fabric side of the two message ports

    initial begin : input_driver
        logic taken;
        forever begin
            @(negedge clk);
            taken = in_valid && in_ready;
            @(posedge clk);
            if (taken || !in_valid) begin
                if (pending.size() > 0) begin
                    in_msg   <= pending.pop_front();
                    in_valid <= 1'b1;
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
    end

    // A word is taken on the edge after this sample
    always @(negedge clk) begin
        if (!reset && out_valid && out_ready) begin
            captured.push_back(out_msg);
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run is stuck", watchdog_cycles);
        $display("Test FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // Record handling

    task automatic load_records();
        int          fd;
        int          n;
        byte         c;
        string       line;
        string       tok;
        string       name;
        logic [47:0] arg;
        fd = $fopen("testbench/pe_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/pe_stim.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0) begin
                c = line.getc(0);
                if (c != "#" && c != "\n" && c != " ") begin
                    arg  = '0;
                    name = "";
                    if (c == "T") begin
                        n = $sscanf(line, "%s %s", tok, name);
                    end else begin
                        n = $sscanf(line, "%s %h", tok, arg);
                    end
                    rec_kind.push_back(c);
                    rec_arg.push_back(arg);
                    rec_name.push_back(name);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_input_drained();
        int cycles;
        cycles = 0;
        while ((pending.size() > 0 || in_valid) && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (pending.size() > 0 || in_valid) begin
            $display("[%s] an injected message was never accepted", test_name);
            other_errors++;
        end
    endtask

    task automatic expect_message(input logic [47:0] exp);
        pe_msg_pkg::pe_msg_u exp_u;
        logic [47:0]         mask;
        logic [47:0]         act;
        int                  cycles;
        exp_u = exp;
        mask  = '1;
        // Own offers carry the node's running timestamp
        if (exp_u.offer.msg_type == pe_msg_pkg::MSG_MATCH_OFFER
                && exp_u.offer.source == SELF_ID) begin
            mask[23:16] = 8'h00;
        end
        cycles = 0;
        while (captured.size() == 0 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (captured.size() == 0) begin
            $display("[%s] no message came out, %h was expected", test_name, exp);
            other_errors++;
        end else begin
            act = captured.pop_front();
            if ((act & mask) != (exp & mask)) begin
                $display("** Error [%s] out_msg: expected %h, actual %h", test_name, exp, act);
                value_errors++;
            end
        end
    endtask

    task automatic check_match_value(input logic [7:0] exp);
        int cycles;
        wait_input_drained();
        cycles = 0;
        @(negedge clk);
        while (match_value_out !== exp && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (match_value_out !== exp) begin
            $display("** Error [%s] match_value_out: expected %h, actual %h",
                     test_name, exp, match_value_out);
            value_errors++;
        end
    endtask

    task automatic check_quiet(input int cycles);
        wait_input_drained();
        repeat (cycles) @(posedge clk);
        while (captured.size() > 0) begin
            $display("[%s] unexpected message %h", test_name, captured.pop_front());
            other_errors++;
        end
    endtask

    // Word frozen and input stalled while out_ready is low
    task automatic check_hold(input int cycles);
        pe_msg_pkg::pe_msg_u held;
        int                  waited;
        waited = 0;
        @(negedge clk);
        while (!out_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!out_valid) begin
            $display("[%s] out_valid never rose", test_name);
            other_errors++;
        end else begin
            held = out_msg;
            repeat (cycles) begin
                @(negedge clk);
                if (!out_valid) begin
                    $display("[%s] out_valid dropped while out_ready was low", test_name);
                    other_errors++;
                end
                if (out_msg != held) begin
                    $display("** Error [%s] held out_msg: expected %h, actual %h",
                             test_name, held, out_msg);
                    value_errors++;
                end
                if (in_ready) begin
                    $display("[%s] in_ready high while the output is stalled", test_name);
                    other_errors++;
                end
            end
        end
    endtask

    task automatic run_record(input int idx);
        case (rec_kind[idx])
            "T": test_name = rec_name[idx];
            "M": begin
                wait_input_drained();
                @(posedge clk);
                measurement_value <= rec_arg[idx][0];
                measurement_valid <= 1'b1;
                @(posedge clk);
                measurement_valid <= 1'b0;
            end
            "S": begin
                wait_input_drained();
                @(posedge clk);
                start_offer <= 1'b1;
                @(posedge clk);
                start_offer <= 1'b0;
            end
            "P": begin
                wait_input_drained();
                @(posedge clk);
                stop_offer <= 1'b1;
                @(posedge clk);
                stop_offer <= 1'b0;
            end
            "I": pending.push_back(rec_arg[idx]);
            "E": expect_message(rec_arg[idx]);
            "V": check_match_value(rec_arg[idx][7:0]);
            "R": begin
                @(posedge clk);
                out_ready <= rec_arg[idx][0];
            end
            "Q": check_quiet(int'(rec_arg[idx]));
            "H": check_hold(int'(rec_arg[idx]));
            default: begin
                $display("Record %0d has an unknown kind", idx);
                other_errors++;
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        clk               = 1'b0;
        reset             = 1'b1;
        measurement_value = 1'b0;
        measurement_valid = 1'b0;
        start_offer       = 1'b0;
        stop_offer        = 1'b0;
        in_msg            = '0;
        in_valid          = 1'b0;
        out_ready         = 1'b1;
        value_errors      = 0;
        other_errors      = 0;
        test_name         = "reset";
        loaded            = 1'b0;
        load_records();
        watchdog_cycles = rec_kind.size() * CYCLES_PER_RECORD + 300;
        loaded          = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("** Error [%s] out_valid: expected 0, actual %b", test_name, out_valid);
            value_errors++;
        end
        foreach (rec_kind[i]) begin
            run_record(i);
        end
        wait_input_drained();
        repeat (10) @(posedge clk);
        while (captured.size() > 0) begin
            $display("Unexpected message %h after the last record", captured.pop_front());
            other_errors++;
        end
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/pe_stim.txt */
# Kind and one hex argument: T name, M bit, S, P, I msg, E msg, V match, R out_ready, Q/H cycles
# Offer msg: rx src broker ts cost hops|type; reply msg: rx src sender target pad type
T reset_idle
V ff
S
Q 12c
V ff
T measured_offer
P
M 1
S
E ff353500fcf0
V ff
T forward_compare
I ff12220508e0
E ff1222050ae0
I ff12220508e0
Q 14
I ff12220507e0
E ff12220509e0
T accept_contract
I ff47460902d0
E ff47460904d0
E 464735350001
I 354646350002
V 46
T contract_reply
P
S
E ff353500fcf0
I 353524240001
E 243535240002
V 24
T refuse_reoffer
P
S
E ff353500fcf0
I ff58570201c0
E ff58570203c0
E 575835350001
I 355757350003
E ff353500fcf0
V ff
T backpressure
R 0
I ff61610310b0
I ff62620411a0
H 14
R 1
E ff61610312b0
E ff62620413a0
T replay_after_stop
P
S
E ff353500fcf0
I ff61610310b0
E ff61610312b0
Q 14

/* flist.f */
hdl/pe_msg_pkg.sv
hdl/pe_node_pkg.sv
hdl/msg_intake.sv
hdl/offer_cache.sv
hdl/qubit_controller.sv
hdl/msg_composer.sv
hdl/pe_top.sv
testbench/tb_pe.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pe
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
